/* common/pix_test_pkg.sv */
// shared widths, scan modes, sequencer states and capture types; capture depth fixed by the chip
`default_nettype none

package pix_test_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------

  // phase counter and every programmed delay share this width
  typedef logic [5:0] phase_t;

  // samples kept per channel, set by the chip readout format
  localparam int dnn_reg_width = 16;

  // newest sample sits in bit 0
  typedef logic [dnn_reg_width-1:0] capture_word_t;

  // ------------------------------------------------------------
  // chip signals
  // ------------------------------------------------------------

  // per-cycle observed outputs of the pixel chip
  typedef struct packed {
    logic dnn_0;
    logic dnn_1;
    logic bxclk_ana;
    logic bxclk;
  } chip_sample_t;

  // captured readout, one shift register per observed signal
  typedef struct packed {
    capture_word_t dnn_0;
    capture_word_t dnn_1;
    capture_word_t bxclk_ana;
    capture_word_t bxclk;
  } capture_set_t;

  // scan chain mode: low shifts serially, high loads the comparators
  typedef logic scan_mode_t;
  localparam scan_mode_t scan_mode_shift_in  = 1'b0;
  localparam scan_mode_t scan_mode_load_comp = 1'b1;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  typedef enum logic [3:0] {
    st_idle,
    st_delay_test,
    st_reset_pulse,
    st_trig_high_1,
    st_trig_high_2,
    st_delay_scanload,
    st_scanload_1,
    st_scanload_2,
    st_done
  } seq_state_t;

  // sequencer to capture block
  typedef enum logic [1:0] {
    cap_hold,
    cap_clear,
    cap_shift
  } capture_cmd_t;

endpackage

`default_nettype wire

/* capture/dnn_capture.sv */
// one command per cycle, applied on the next edge; samples must be synchronous to clk
`default_nettype none
`timescale 1ns/1ps

module dnn_capture (
  input  logic                       clk,
  input  logic                       test_mask_reset_not,
  input  pix_test_pkg::capture_cmd_t capture_cmd,
  input  pix_test_pkg::chip_sample_t sample,
  output pix_test_pkg::capture_set_t captured
);

  import pix_test_pkg::*;

  capture_set_t shifted;

  // ------------------------------------------------------------
  // shift path, newest sample enters at bit 0
  // ------------------------------------------------------------
  always_comb begin
    shifted.dnn_0     = {captured.dnn_0[dnn_reg_width-2:0], sample.dnn_0};
    shifted.dnn_1     = {captured.dnn_1[dnn_reg_width-2:0], sample.dnn_1};
    shifted.bxclk_ana = {captured.bxclk_ana[dnn_reg_width-2:0], sample.bxclk_ana};
    shifted.bxclk     = {captured.bxclk[dnn_reg_width-2:0], sample.bxclk};
  end

  // ------------------------------------------------------------
  // capture registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      captured <= '0;
    end else begin
      case (capture_cmd)
        cap_clear: begin
          captured <= '0;
        end
        cap_shift: begin
          captured <= shifted;
        end
        default: begin
          // hold keeps the readout stable until the next run clears it
          captured <= captured;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* sequencer/scan_test_sequencer.sv */
// phase_count must free-run modulo 64 and the delay inputs must stay stable for a whole run
`default_nettype none
`timescale 1ns/1ps

module scan_test_sequencer (
  input  logic                      clk,
  input  logic                      test_mask_reset_not,
  input  logic                      start,
  input  logic                      reset_pulse_mask,
  input  logic                      scan_load_delay_disable,
  input  pix_test_pkg::phase_t      phase_count,
  input  pix_test_pkg::phase_t      test_delay,
  input  pix_test_pkg::phase_t      trig_phase,
  input  pix_test_pkg::phase_t      scan_load_delay,
  output logic                      chip_reset_n,
  output logic                      trig_out,
  output logic                      done,
  output pix_test_pkg::scan_mode_t  scan_load,
  output pix_test_pkg::capture_cmd_t capture_cmd
);

  import pix_test_pkg::*;

  seq_state_t state;
  seq_state_t state_next;
  phase_t     delay_cnt;
  phase_t     delay_cnt_next;
  scan_mode_t scan_load_next;
  logic       chip_reset_n_next;
  logic       phase_match;
  logic       delay_reached;
  // level driven on chip reset while the pulse is active
  logic       reset_level;

  // a step ends on the cycle where the phase counter hits the programmed delay
  assign phase_match   = (phase_count == test_delay);
  assign delay_reached = (delay_cnt == scan_load_delay);
  assign reset_level   = reset_pulse_mask;

  // ------------------------------------------------------------
  // next state and registered output values
  // ------------------------------------------------------------
  always_comb begin
    state_next        = state;
    delay_cnt_next    = '0;
    scan_load_next    = scan_mode_load_comp;
    chip_reset_n_next = 1'b1;
    capture_cmd       = cap_clear;

    case (state)
      st_idle: begin
        if (start) begin
          state_next = st_delay_test;
        end else begin
          capture_cmd = cap_hold;
        end
      end

      st_delay_test: begin
        if (phase_match) begin
          state_next        = st_reset_pulse;
          chip_reset_n_next = reset_level;
          scan_load_next    = scan_mode_shift_in;
        end
      end

      st_reset_pulse: begin
        if (phase_match) begin
          state_next = st_trig_high_1;
          // disable path leaves shift mode at the end of the pulse
          scan_load_next = scan_load_delay_disable ? scan_mode_load_comp : scan_mode_shift_in;
        end else begin
          chip_reset_n_next = reset_level;
          scan_load_next    = scan_mode_shift_in;
        end
      end

      st_trig_high_1: begin
        scan_load_next = scan_load_delay_disable ? scan_mode_load_comp : scan_mode_shift_in;
        if (phase_match) begin
          state_next = st_trig_high_2;
        end
      end

      st_trig_high_2: begin
        if (scan_load_delay_disable) begin
          // no scan load in this path, capture runs during the trigger fall
          capture_cmd = cap_shift;
          if (phase_match) begin
            state_next = st_done;
          end
        end else begin
          scan_load_next = scan_mode_shift_in;
          if (phase_match) begin
            delay_cnt_next = delay_cnt + phase_t'(1);
            if (scan_load_delay == '0) begin
              state_next     = st_scanload_1;
              scan_load_next = scan_mode_load_comp;
            end else begin
              state_next = st_delay_scanload;
            end
          end
        end
      end

      st_delay_scanload: begin
        scan_load_next = scan_mode_shift_in;
        delay_cnt_next = delay_cnt;
        if (phase_match) begin
          if (delay_reached) begin
            state_next     = st_scanload_1;
            scan_load_next = scan_mode_load_comp;
            delay_cnt_next = '0;
          end else begin
            delay_cnt_next = delay_cnt + phase_t'(1);
          end
        end
      end

      st_scanload_1: begin
        if (phase_match) begin
          state_next = st_scanload_2;
        end
      end

      st_scanload_2: begin
        capture_cmd = cap_shift;
        if (phase_match) begin
          state_next = st_done;
        end
      end

      st_done: begin
        state_next  = st_idle;
        capture_cmd = cap_hold;
      end

      default: begin
        state_next = st_idle;
      end
    endcase
  end

  // ------------------------------------------------------------
  // state and output registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      state        <= st_idle;
      delay_cnt    <= '0;
      scan_load    <= scan_mode_load_comp;
      chip_reset_n <= 1'b1;
      done         <= 1'b0;
    end else begin
      state        <= state_next;
      delay_cnt    <= delay_cnt_next;
      scan_load    <= scan_load_next;
      chip_reset_n <= chip_reset_n_next;
      // one cycle pulse after the done state
      done         <= (state == st_done);
    end
  end

  // trigger rises in trig-high-1 and falls in trig-high-2 at the same phase,
  // so the high time is one full phase period
  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      trig_out <= 1'b0;
    end else if (phase_count == trig_phase) begin
      if (state == st_trig_high_1) begin
        trig_out <= 1'b1;
      end else if (state == st_trig_high_2) begin
        trig_out <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/pix_scan_test_top.sv */
// start is ignored outside idle; captured is valid from done until the next start
`default_nettype none
`timescale 1ns/1ps

module pix_scan_test_top (
  input  logic                       clk,
  input  logic                       test_mask_reset_not,
  input  logic                       start,
  input  logic                       reset_pulse_mask,
  input  logic                       scan_load_delay_disable,
  input  pix_test_pkg::phase_t       phase_count,
  input  pix_test_pkg::phase_t       test_delay,
  input  pix_test_pkg::phase_t       trig_phase,
  input  pix_test_pkg::phase_t       scan_load_delay,
  input  pix_test_pkg::chip_sample_t sample,
  output logic                       chip_reset_n,
  output logic                       trig_out,
  output logic                       done,
  output pix_test_pkg::scan_mode_t   scan_load,
  output pix_test_pkg::capture_set_t captured
);

  import pix_test_pkg::*;

  // clear/shift/hold from the sequencer to the capture registers
  capture_cmd_t capture_cmd;

  scan_test_sequencer scan_test_sequencer_inst (
    .clk                     (clk),
    .test_mask_reset_not     (test_mask_reset_not),
    .start                   (start),
    .reset_pulse_mask        (reset_pulse_mask),
    .scan_load_delay_disable (scan_load_delay_disable),
    .phase_count             (phase_count),
    .test_delay              (test_delay),
    .trig_phase              (trig_phase),
    .scan_load_delay         (scan_load_delay),
    .chip_reset_n            (chip_reset_n),
    .trig_out                (trig_out),
    .done                    (done),
    .scan_load               (scan_load),
    .capture_cmd             (capture_cmd)
  );

  dnn_capture dnn_capture_inst (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .capture_cmd         (capture_cmd),
    .sample              (sample),
    .captured            (captured)
  );

endmodule

`default_nettype wire

/* tests/pix_scan_test_assertions.sv */
// bound into pix_scan_test_top; all properties are sampled on clk and counted in failures
`default_nettype none
`timescale 1ns/1ps

module pix_scan_test_assertions (
  input logic                       clk,
  input logic                       test_mask_reset_not,
  input logic                       reset_pulse_mask,
  input pix_test_pkg::phase_t       phase_count,
  input pix_test_pkg::phase_t       trig_phase,
  input logic                       chip_reset_n,
  input logic                       trig_out,
  input logic                       done,
  input pix_test_pkg::scan_mode_t   scan_load,
  input pix_test_pkg::capture_cmd_t capture_cmd,
  input pix_test_pkg::capture_set_t captured
);

  import pix_test_pkg::*;

  int failures = 0;

  // ------------------------------------------------------------
  // reset and handshake
  // ------------------------------------------------------------
  reset_values_a: assert property (@(posedge clk)
    test_mask_reset_not |=> (!done && !trig_out && chip_reset_n &&
                             scan_load == scan_mode_load_comp && captured == '0))
    else begin
      $error("outputs not at their reset values");
      failures++;
    end

  done_pulse_a: assert property (@(posedge clk) disable iff (test_mask_reset_not)
    done |=> !done)
    else begin
      $error("done longer than one cycle");
      failures++;
    end

  // chip is back in comparator-load mode when the run reports done
  done_load_comp_a: assert property (@(posedge clk) disable iff (test_mask_reset_not)
    done |-> scan_load == scan_mode_load_comp)
    else begin
      $error("scan_load not in load-comp at done");
      failures++;
    end

  // ------------------------------------------------------------
  // chip controls
  // ------------------------------------------------------------
  trig_rise_phase_a: assert property (@(posedge clk) disable iff (test_mask_reset_not)
    $rose(trig_out) |-> $past(phase_count) == $past(trig_phase))
    else begin
      $error("trig_out rose off the trigger phase");
      failures++;
    end

  mask_keeps_reset_high_a: assert property (@(posedge clk) disable iff (test_mask_reset_not)
    reset_pulse_mask |-> chip_reset_n)
    else begin
      $error("chip_reset_n low while masked");
      failures++;
    end

  reset_in_shift_mode_a: assert property (@(posedge clk) disable iff (test_mask_reset_not)
    !chip_reset_n |-> scan_load == scan_mode_shift_in)
    else begin
      $error("scan_load not in shift-in during the reset pulse");
      failures++;
    end

  hold_keeps_capture_a: assert property (@(posedge clk) disable iff (test_mask_reset_not)
    capture_cmd == cap_hold |=> $stable(captured))
    else begin
      $error("captured changed on a hold command");
      failures++;
    end

endmodule

bind pix_scan_test_top pix_scan_test_assertions pix_scan_test_assertions_inst (
  .clk                 (clk),
  .test_mask_reset_not (test_mask_reset_not),
  .reset_pulse_mask    (reset_pulse_mask),
  .phase_count         (phase_count),
  .trig_phase          (trig_phase),
  .chip_reset_n        (chip_reset_n),
  .trig_out            (trig_out),
  .done                (done),
  .scan_load           (scan_load),
  .capture_cmd         (capture_cmd),
  .captured            (captured)
);

`default_nettype wire

/* tests/pix_scan_test_tb.sv */
// phase_count free-runs from time zero; config inputs change only while the sequencer is idle
`default_nettype none
`timescale 1ns/1ps

module pix_scan_test_tb;

  import pix_test_pkg::*;

  localparam int period_cycles = 64;
  localparam int run_timeout   = 64 * 16;
  localparam int idle_gap      = 20;

  logic         clk;
  logic         test_mask_reset_not;
  logic         start;
  logic         reset_pulse_mask;
  logic         scan_load_delay_disable;
  phase_t       phase_count;
  phase_t       test_delay;
  phase_t       trig_phase;
  phase_t       scan_load_delay;
  chip_sample_t sample;
  logic         chip_reset_n;
  logic         trig_out;
  logic         done;
  scan_mode_t   scan_load;
  capture_set_t captured;

  logic [31:0]  rng_state;
  string        test_name;
  int           errors;
  int           checks;
  int           runs_done;
  int           cycle_no;
  int           fall_cycle;
  int           reset_low_len;
  int           trig_high_len;
  int           run_falls;
  int           run_trig_rises;
  logic         prev_reset_n;
  logic         prev_trig;
  logic         prev_done;
  logic         holding;
  logic         timed_out;
  phase_t       phase_at_edge;
  // samples seen on every edge and the same history one edge earlier
  capture_set_t history;
  capture_set_t history_before;
  capture_set_t held_value;

  pix_scan_test_top pix_scan_test_top_inst (
    .clk                     (clk),
    .test_mask_reset_not     (test_mask_reset_not),
    .start                   (start),
    .reset_pulse_mask        (reset_pulse_mask),
    .scan_load_delay_disable (scan_load_delay_disable),
    .phase_count             (phase_count),
    .test_delay              (test_delay),
    .trig_phase              (trig_phase),
    .scan_load_delay         (scan_load_delay),
    .sample                  (sample),
    .chip_reset_n            (chip_reset_n),
    .trig_out                (trig_out),
    .done                    (done),
    .scan_load               (scan_load),
    .captured                (captured)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error [%s] %s: expected 0x%0h, actual 0x%0h", test_name, name, expected, actual);
    end
  endtask

  task automatic report_and_finish();
    int assert_fails;
    assert_fails = pix_scan_test_top_inst.pix_scan_test_assertions_inst.failures;
    $display("runs: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             runs_done, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // ------------------------------------------------------------
  // expected results at the rise of done
  // ------------------------------------------------------------
  task automatic check_run_result();
    int steps;
    // reset pulse, both trigger halves, then the scan-load steps if enabled
    steps = scan_load_delay_disable ? 3 : 5 + int'(scan_load_delay);
    check_value("dnn_0 capture", 64'(history_before.dnn_0), 64'(captured.dnn_0));
    check_value("dnn_1 capture", 64'(history_before.dnn_1), 64'(captured.dnn_1));
    check_value("bxclk_ana capture", 64'(history_before.bxclk_ana), 64'(captured.bxclk_ana));
    check_value("bxclk capture", 64'(history_before.bxclk), 64'(captured.bxclk));
    check_value("trigger rises per run", 64'(1), 64'(run_trig_rises));
    if (reset_pulse_mask) begin
      check_value("reset pulses per run", 64'(0), 64'(run_falls));
    end else begin
      check_value("reset pulses per run", 64'(1), 64'(run_falls));
      check_value("reset fall to done", 64'(period_cycles * steps + 2),
                  64'(cycle_no - fall_cycle + 1));
    end
    held_value = captured;
    holding    = 1'b1;
  endtask

  task automatic monitor_outputs();
    if (!chip_reset_n) begin
      if (prev_reset_n) begin
        run_falls++;
        fall_cycle    = cycle_no;
        reset_low_len = 0;
      end
      reset_low_len++;
    end else if (!prev_reset_n) begin
      check_value("reset pulse length", 64'(period_cycles), 64'(reset_low_len));
    end

    if (trig_out && !prev_trig) begin
      run_trig_rises++;
      trig_high_len = 0;
      check_value("trigger rise phase", 64'(trig_phase), 64'(phase_at_edge));
    end
    if (trig_out) begin
      trig_high_len++;
    end else if (prev_trig) begin
      check_value("trigger high length", 64'(period_cycles), 64'(trig_high_len));
    end

    if (done && prev_done) begin
      errors++;
      $display("[%s] done stayed high for more than one cycle", test_name);
    end
    if (holding) begin
      check_value("captured hold", 64'(held_value), 64'(captured));
    end
    if (done && !prev_done) begin
      check_run_result();
    end
  endtask

  // each clock records the edge, looks at the outputs and then drives the next inputs
  task automatic step_cycle();
    @(posedge clk);
    phase_at_edge  = phase_count;
    history_before = history;
    history.dnn_0     = {history.dnn_0[dnn_reg_width-2:0], sample.dnn_0};
    history.dnn_1     = {history.dnn_1[dnn_reg_width-2:0], sample.dnn_1};
    history.bxclk_ana = {history.bxclk_ana[dnn_reg_width-2:0], sample.bxclk_ana};
    history.bxclk     = {history.bxclk[dnn_reg_width-2:0], sample.bxclk};
    #1;
    cycle_no++;
    if (!test_mask_reset_not) begin
      monitor_outputs();
    end
    prev_reset_n = chip_reset_n;
    prev_trig    = trig_out;
    prev_done    = done;
    phase_count  = phase_count + phase_t'(1);
    rng_state    = xorshift32(rng_state);
    sample       = chip_sample_t'(rng_state[3:0]);
  endtask

  task automatic run_test(input string name, input logic disable_delay,
                          input phase_t delay, input logic mask);
    int n;
    // a run that timed out leaves the sequencer busy, so later runs are skipped
    if (timed_out) begin
      return;
    end
    test_name               = name;
    scan_load_delay_disable = disable_delay;
    scan_load_delay         = delay;
    reset_pulse_mask        = mask;
    run_falls               = 0;
    run_trig_rises          = 0;
    step_cycle();
    start   = 1'b1;
    holding = 1'b0;
    step_cycle();
    start = 1'b0;
    n     = 0;
    while (!done && n < run_timeout) begin
      step_cycle();
      n++;
    end
    if (done) begin
      runs_done++;
      repeat (idle_gap) step_cycle();
    end else begin
      errors++;
      timed_out = 1'b1;
      $display("[%s] timeout, done not seen within %0d cycles", test_name, run_timeout);
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    clk                     = 1'b0;
    test_mask_reset_not     = 1'b1;
    start                   = 1'b0;
    reset_pulse_mask        = 1'b0;
    scan_load_delay_disable = 1'b0;
    phase_count             = '0;
    test_delay              = 6'd10;
    trig_phase              = 6'd37;
    scan_load_delay         = 6'd2;
    sample                  = '0;
    rng_state               = 32'he302;
    history                 = '0;
    history_before          = '0;
    held_value              = '0;
    test_name               = "reset";
    errors                  = 0;
    checks                  = 0;
    runs_done               = 0;
    cycle_no                = 0;
    fall_cycle              = 0;
    reset_low_len           = 0;
    trig_high_len           = 0;
    run_falls               = 0;
    run_trig_rises          = 0;
    prev_reset_n            = 1'b1;
    prev_trig               = 1'b0;
    prev_done               = 1'b0;
    holding                 = 1'b0;
    timed_out               = 1'b0;
    phase_at_edge           = '0;

    repeat (8) step_cycle();
    test_mask_reset_not = 1'b0;
    check_value("done after reset", 64'(0), 64'(done));
    check_value("trig_out after reset", 64'(0), 64'(trig_out));
    check_value("chip_reset_n after reset", 64'(1), 64'(chip_reset_n));
    check_value("scan_load after reset", 64'(scan_mode_load_comp), 64'(scan_load));
    check_value("captured after reset", 64'(0), 64'(captured));
    repeat (idle_gap) step_cycle();

    run_test("delay_2", 1'b0, 6'd2, 1'b0);
    run_test("delay_0", 1'b0, 6'd0, 1'b0);
    run_test("delay_disabled", 1'b1, 6'd2, 1'b0);
    run_test("reset_masked", 1'b0, 6'd1, 1'b1);
    report_and_finish();
  end

endmodule

`default_nettype wire

/* pix_scan_test.f */
common/pix_test_pkg.sv
capture/dnn_capture.sv
sequencer/scan_test_sequencer.sv
hdl/pix_scan_test_top.sv
tests/pix_scan_test_assertions.sv
tests/pix_scan_test_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := pix_scan_test_tb
FILE_LIST  := pix_scan_test.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := All checks passed
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)
RUN_FLAGS  := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST)

# the simulator status is not trusted, the log decides
run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
